//--- lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    localparam lc3b_word nop_instr = 16'h0000;   // BR with nzp clear

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_alu_op;

    typedef enum logic {
        lc3b_regfile_sr1_mux_sel_sr1,    // ir[8:6]
        lc3b_regfile_sr1_mux_sel_dest    // ir[11:9]
    } lc3b_regfile_sr1_mux_sel;

    typedef enum logic {
        lc3b_regfile_sr2_mux_sel_sr2,    // ir[2:0]
        lc3b_regfile_sr2_mux_sel_dest    // ir[11:9], store source
    } lc3b_regfile_sr2_mux_sel;

    typedef enum logic {
        lc3b_cc_gen_mux_sel_alu,
        lc3b_cc_gen_mux_sel_mdr
    } lc3b_cc_gen_mux_sel;

    typedef enum logic [2:0] {
        lc3b_alu_mux_sel_sr2       = 3'b000,
        lc3b_alu_mux_sel_imm4      = 3'b001,
        lc3b_alu_mux_sel_imm5      = 3'b010,
        lc3b_alu_mux_sel_offset6_w = 3'b100
    } lc3b_alu_mux_sel;

    typedef enum logic [2:0] {
        lc3b_regfile_data_mux_sel_none = 3'b000,
        lc3b_regfile_data_mux_sel_mdr  = 3'b010,
        lc3b_regfile_data_mux_sel_pc   = 3'b100,   // link value
        lc3b_regfile_data_mux_sel_alu  = 3'b101
    } lc3b_regfile_data_mux_sel;

    typedef struct packed {
        logic                     branch;
        lc3b_regfile_sr1_mux_sel  regfile_sr1_mux_sel;
        lc3b_regfile_sr2_mux_sel  regfile_sr2_mux_sel;
        logic                     pc_adder_mux_sel;      // 0 offset9, 1 offset11
        lc3b_alu_mux_sel          general_alu_mux_sel;
        lc3b_alu_op               general_alu_op;
        logic                     cc_load;
        lc3b_cc_gen_mux_sel       cc_gen_mux_sel;
        logic                     br_en_load;
        logic                     internal_mdr_load;
        logic                     data_memory_write_enable;
        logic [1:0]               data_memory_addr_mux_sel;
        logic [1:0]               data_memory_byte_sel;
        lc3b_regfile_data_mux_sel regfile_data_mux_sel;
        logic                     regfile_dest_mux_sel;  // 1 selects r7
        logic                     regfile_load;
    } lc3b_control_word;

    typedef struct packed {
        logic     valid;
        lc3b_word pc_plus2;
        lc3b_word ir;
    } if_id_t;

    typedef struct packed {
        logic             valid;
        lc3b_word         pc_plus2;
        lc3b_word         ir;
        lc3b_control_word ctrl;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        lc3b_word         pc_plus2;
        lc3b_word         ir;
        lc3b_control_word ctrl;
        lc3b_word         alu_out;
        lc3b_word         target;      // pc adder result
        lc3b_word         store_data;
    } ex_mem_t;

    typedef struct packed {
        logic             valid;
        lc3b_word         pc_plus2;
        lc3b_word         ir;
        lc3b_control_word ctrl;
        lc3b_word         alu_out;
        lc3b_word         mdr;
    } mem_wb_t;

endpackage : lc3b_types

//--- control_rom.sv
`timescale 1ns/1ps

module control_rom (
    input  lc3b_types::lc3b_word         ir_in,
    output lc3b_types::lc3b_control_word control_out
);

    lc3b_types::lc3b_opcode opcode;

    assign opcode = lc3b_types::lc3b_opcode'(ir_in[15:12]);

    always_comb begin
        // inactive defaults for every stage
        control_out.branch                   = 1'b0;
        control_out.regfile_sr1_mux_sel      = lc3b_types::lc3b_regfile_sr1_mux_sel_sr1;
        control_out.regfile_sr2_mux_sel      = lc3b_types::lc3b_regfile_sr2_mux_sel_sr2;
        control_out.pc_adder_mux_sel         = 1'b0;
        control_out.general_alu_mux_sel      = lc3b_types::lc3b_alu_mux_sel_sr2;
        control_out.general_alu_op           = lc3b_types::alu_pass;
        control_out.cc_load                  = 1'b0;
        control_out.cc_gen_mux_sel           = lc3b_types::lc3b_cc_gen_mux_sel_alu;
        control_out.br_en_load               = 1'b0;
        control_out.internal_mdr_load        = 1'b0;
        control_out.data_memory_write_enable = 1'b0;
        control_out.data_memory_addr_mux_sel = 2'b00;
        control_out.data_memory_byte_sel     = 2'b00;
        control_out.regfile_data_mux_sel     = lc3b_types::lc3b_regfile_data_mux_sel_none;
        control_out.regfile_dest_mux_sel     = 1'b0;
        control_out.regfile_load             = 1'b0;

        case (opcode)
            lc3b_types::op_add, lc3b_types::op_and: begin
                if (ir_in[5])
                    control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm5;
                else
                    control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_sr2;
                if (opcode == lc3b_types::op_add)
                    control_out.general_alu_op = lc3b_types::alu_add;
                else
                    control_out.general_alu_op = lc3b_types::alu_and;
                control_out.cc_load              = 1'b1;
                control_out.regfile_data_mux_sel = lc3b_types::lc3b_regfile_data_mux_sel_alu;
                control_out.regfile_load         = 1'b1;
            end

            lc3b_types::op_not: begin
                control_out.general_alu_op       = lc3b_types::alu_not;
                control_out.cc_load              = 1'b1;
                control_out.regfile_data_mux_sel = lc3b_types::lc3b_regfile_data_mux_sel_alu;
                control_out.regfile_load         = 1'b1;
            end

            lc3b_types::op_shf: begin
                control_out.general_alu_mux_sel = lc3b_types::lc3b_alu_mux_sel_imm4;
                if (!ir_in[4])
                    control_out.general_alu_op = lc3b_types::alu_sll;
                else if (!ir_in[5])
                    control_out.general_alu_op = lc3b_types::alu_srl;   // zero fill
                else
                    control_out.general_alu_op = lc3b_types::alu_sra;   // sign fill
                control_out.cc_load              = 1'b1;
                control_out.regfile_data_mux_sel = lc3b_types::lc3b_regfile_data_mux_sel_alu;
                control_out.regfile_load         = 1'b1;
            end

            lc3b_types::op_ldr: begin
                control_out.general_alu_mux_sel      = lc3b_types::lc3b_alu_mux_sel_offset6_w;
                control_out.general_alu_op           = lc3b_types::alu_add;
                control_out.cc_load                  = 1'b1;
                control_out.cc_gen_mux_sel           = lc3b_types::lc3b_cc_gen_mux_sel_mdr;
                control_out.internal_mdr_load        = 1'b1;
                control_out.data_memory_addr_mux_sel = 2'b01;   // alu
                control_out.data_memory_byte_sel     = 2'b11;   // full word
                control_out.regfile_data_mux_sel     = lc3b_types::lc3b_regfile_data_mux_sel_mdr;
                control_out.regfile_load             = 1'b1;
            end

            lc3b_types::op_str: begin
                control_out.regfile_sr2_mux_sel      = lc3b_types::lc3b_regfile_sr2_mux_sel_dest;
                control_out.general_alu_mux_sel      = lc3b_types::lc3b_alu_mux_sel_offset6_w;
                control_out.general_alu_op           = lc3b_types::alu_add;
                control_out.data_memory_write_enable = 1'b1;
                control_out.data_memory_addr_mux_sel = 2'b01;
                control_out.data_memory_byte_sel     = 2'b11;
            end

            lc3b_types::op_br: begin
                control_out.branch           = 1'b1;
                control_out.pc_adder_mux_sel = 1'b0;   // offset9
                control_out.br_en_load       = 1'b1;
            end

            default: begin
                control_out = '0;   // unsupported opcode acts as a bubble
            end
        endcase
    end

    // a word that both stores and writes back would corrupt the register file
    always_comb begin
        assert final (!(control_out.data_memory_write_enable && control_out.regfile_load))
            else $error("control_rom: store and regfile load together, ir %h", ir_in);
    end

endmodule : control_rom

//--- regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                load,
    input  lc3b_types::lc3b_reg  dest,
    input  lc3b_types::lc3b_reg  src_a,
    input  lc3b_types::lc3b_reg  src_b,
    input  lc3b_types::lc3b_word in,
    output lc3b_types::lc3b_word reg_a,
    output lc3b_types::lc3b_word reg_b
);

    lc3b_types::lc3b_word data [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                data[i] <= '0;
            end
        end else if (load) begin
            data[dest] <= in;
        end
    end

    // write-through so ID sees the WB result in the same cycle
    assign reg_a = (load && (src_a == dest)) ? in : data[src_a];
    assign reg_b = (load && (src_b == dest)) ? in : data[src_b];

endmodule : regfile

//--- general_alu.sv
`timescale 1ns/1ps

module general_alu (
    input  lc3b_types::lc3b_alu_op aluop,
    input  lc3b_types::lc3b_word   a,
    input  lc3b_types::lc3b_word   b,
    output lc3b_types::lc3b_word   f
);

    logic [3:0] shamt;

    assign shamt = b[3:0];   // imm4 field

    always_comb begin
        case (aluop)
            lc3b_types::alu_add:  f = a + b;
            lc3b_types::alu_and:  f = a & b;
            lc3b_types::alu_not:  f = ~a;
            lc3b_types::alu_pass: f = a;
            lc3b_types::alu_sll:  f = a << shamt;
            lc3b_types::alu_srl:  f = a >> shamt;
            lc3b_types::alu_sra:  f = $signed(a) >>> shamt;   // keeps sign bit
            default:              f = a;
        endcase
    end

endmodule : general_alu

//--- stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // cleared slot has valid and control word low, so it acts as a nop
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule : stage_reg

//--- cc_branch_unit.sv
`timescale 1ns/1ps

module cc_branch_unit (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lc3b_types::lc3b_control_word ctrl,
    input  lc3b_types::lc3b_nzp          nzp_field,
    input  lc3b_types::lc3b_word         result,
    output logic                         branch_taken
);

    lc3b_types::lc3b_nzp nzp;
    lc3b_types::lc3b_nzp nzp_next;

    always_comb begin
        if (result[15])
            nzp_next = 3'b100;
        else if (result == '0)
            nzp_next = 3'b010;
        else
            nzp_next = 3'b001;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            nzp <= 3'b010;   // z after reset
        end else if (ctrl.cc_load) begin
            nzp <= nzp_next;
        end
    end

    assign branch_taken = ctrl.branch && ctrl.br_en_load && |(nzp_field & nzp);

    a_nzp_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(nzp))
        else $error("cc_branch_unit: nzp not one-hot, %b", nzp);

endmodule : cc_branch_unit

//--- lc3b_pipeline.sv
`timescale 1ns/1ps

module lc3b_pipeline (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_types::lc3b_word imem_rdata,
    input  lc3b_types::lc3b_word dmem_rdata,
    output lc3b_types::lc3b_word imem_addr,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 dmem_we,
    output logic [1:0]           dmem_byte_sel
);

    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word pc_plus2;
    logic                 branch_taken;

    lc3b_types::if_id_t  if_id_d, if_id_q;
    lc3b_types::id_ex_t  id_ex_d, id_ex_q;
    lc3b_types::ex_mem_t ex_mem_d, ex_mem_q;
    lc3b_types::mem_wb_t mem_wb_d, mem_wb_q;

    lc3b_types::lc3b_word         id_ir;
    lc3b_types::lc3b_control_word id_ctrl;
    lc3b_types::lc3b_reg          src_a, src_b, wb_dest;
    lc3b_types::lc3b_word         reg_a, reg_b;
    lc3b_types::lc3b_word         alu_b, alu_f, pc_offset;
    lc3b_types::lc3b_word         mdr, cc_result, wb_data;

    // IF
    assign imem_addr = pc;
    assign pc_plus2  = pc + 16'd2;

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= '0;
        else if (branch_taken)
            pc <= ex_mem_q.target;   // redirect from MEM
        else
            pc <= pc_plus2;
    end

    assign if_id_d = '{valid: 1'b1, pc_plus2: pc_plus2, ir: imem_rdata};

    // ID
    assign id_ir = if_id_q.valid ? if_id_q.ir : lc3b_types::nop_instr;
    assign src_a = (id_ctrl.regfile_sr1_mux_sel == lc3b_types::lc3b_regfile_sr1_mux_sel_dest)
                   ? id_ir[11:9] : id_ir[8:6];
    assign src_b = (id_ctrl.regfile_sr2_mux_sel == lc3b_types::lc3b_regfile_sr2_mux_sel_dest)
                   ? id_ir[11:9] : id_ir[2:0];

    control_rom control_rom_inst (.ir_in(id_ir), .control_out(id_ctrl));

    regfile regfile_inst (
        .clk(clk), .rst_n(rst_n), .load(mem_wb_q.ctrl.regfile_load), .dest(wb_dest),
        .src_a(src_a), .src_b(src_b), .in(wb_data), .reg_a(reg_a), .reg_b(reg_b)
    );

    assign id_ex_d = '{valid: if_id_q.valid, pc_plus2: if_id_q.pc_plus2, ir: id_ir,
                       ctrl: id_ctrl, sr1_data: reg_a, sr2_data: reg_b};

    // EX operand mux with sign extension of the immediates
    always_comb begin
        case (id_ex_q.ctrl.general_alu_mux_sel)
            lc3b_types::lc3b_alu_mux_sel_imm4: alu_b = {12'b0, id_ex_q.ir[3:0]};
            lc3b_types::lc3b_alu_mux_sel_imm5: alu_b = {{11{id_ex_q.ir[4]}}, id_ex_q.ir[4:0]};
            lc3b_types::lc3b_alu_mux_sel_offset6_w:
                alu_b = {{9{id_ex_q.ir[5]}}, id_ex_q.ir[5:0], 1'b0};
            default: alu_b = id_ex_q.sr2_data;
        endcase
    end

    assign pc_offset = id_ex_q.ctrl.pc_adder_mux_sel
                       ? {{4{id_ex_q.ir[10]}}, id_ex_q.ir[10:0], 1'b0}   // offset11
                       : {{6{id_ex_q.ir[8]}}, id_ex_q.ir[8:0], 1'b0};    // offset9

    general_alu general_alu_inst (
        .aluop(id_ex_q.ctrl.general_alu_op), .a(id_ex_q.sr1_data), .b(alu_b), .f(alu_f)
    );

    assign ex_mem_d = '{valid: id_ex_q.valid, pc_plus2: id_ex_q.pc_plus2, ir: id_ex_q.ir,
                        ctrl: id_ex_q.ctrl, alu_out: alu_f,
                        target: id_ex_q.pc_plus2 + pc_offset, store_data: id_ex_q.sr2_data};

    // MEM
    always_comb begin
        case (ex_mem_q.ctrl.data_memory_addr_mux_sel)
            2'b01:   dmem_addr = ex_mem_q.alu_out;
            2'b10:   dmem_addr = ex_mem_q.target;
            default: dmem_addr = '0;
        endcase
    end

    assign dmem_wdata    = ex_mem_q.store_data;
    assign dmem_we       = ex_mem_q.ctrl.data_memory_write_enable;
    assign dmem_byte_sel = ex_mem_q.ctrl.data_memory_byte_sel;
    assign mdr           = ex_mem_q.ctrl.internal_mdr_load ? dmem_rdata : '0;
    assign cc_result     = (ex_mem_q.ctrl.cc_gen_mux_sel == lc3b_types::lc3b_cc_gen_mux_sel_mdr)
                           ? mdr : ex_mem_q.alu_out;

    cc_branch_unit cc_branch_unit_inst (
        .clk(clk), .rst_n(rst_n), .ctrl(ex_mem_q.ctrl), .nzp_field(ex_mem_q.ir[11:9]),
        .result(cc_result), .branch_taken(branch_taken)
    );

    assign mem_wb_d = '{valid: ex_mem_q.valid, pc_plus2: ex_mem_q.pc_plus2, ir: ex_mem_q.ir,
                        ctrl: ex_mem_q.ctrl, alu_out: ex_mem_q.alu_out, mdr: mdr};

    // WB
    assign wb_dest = mem_wb_q.ctrl.regfile_dest_mux_sel ? 3'd7 : mem_wb_q.ir[11:9];

    always_comb begin
        case (mem_wb_q.ctrl.regfile_data_mux_sel)
            lc3b_types::lc3b_regfile_data_mux_sel_mdr: wb_data = mem_wb_q.mdr;
            lc3b_types::lc3b_regfile_data_mux_sel_pc:  wb_data = mem_wb_q.pc_plus2;
            default:                                   wb_data = mem_wb_q.alu_out;
        endcase
    end

    // taken branch kills the three younger slots
    stage_reg #(.payload_t(lc3b_types::if_id_t)) if_id_reg (
        .clk(clk), .rst_n(rst_n), .flush(branch_taken), .d(if_id_d), .q(if_id_q)
    );
    stage_reg #(.payload_t(lc3b_types::id_ex_t)) id_ex_reg (
        .clk(clk), .rst_n(rst_n), .flush(branch_taken), .d(id_ex_d), .q(id_ex_q)
    );
    stage_reg #(.payload_t(lc3b_types::ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst_n(rst_n), .flush(branch_taken), .d(ex_mem_d), .q(ex_mem_q)
    );
    stage_reg #(.payload_t(lc3b_types::mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst_n(rst_n), .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    a_we_valid: assert property (@(posedge clk) disable iff (!rst_n) dmem_we |-> ex_mem_q.valid)
        else $error("lc3b_pipeline: dmem write from an invalid MEM slot");

endmodule : lc3b_pipeline

//--- tb_lc3b_pipeline.sv
`timescale 1ns/1ps

module tb_lc3b_pipeline;

    logic                 clk;
    logic                 rst_n;
    lc3b_types::lc3b_word imem_rdata;
    lc3b_types::lc3b_word dmem_rdata;
    lc3b_types::lc3b_word imem_addr;
    lc3b_types::lc3b_word dmem_addr;
    lc3b_types::lc3b_word dmem_wdata;
    logic                 dmem_we;
    logic [1:0]           dmem_byte_sel;

    lc3b_types::lc3b_word imem [128];
    lc3b_types::lc3b_word dmem [256];
    lc3b_types::lc3b_word seed_words [256];
    lc3b_types::lc3b_word prog [$];        // program table
    string                st_name [$];     // expectation table, one entry per store
    lc3b_types::lc3b_word st_addr [$];
    lc3b_types::lc3b_word st_data [$];
    lc3b_types::lc3b_word jump_target [$];
    int                   store_ptr;
    int                   jump_ptr;
    int                   checks;
    int                   errors;
    lc3b_types::lc3b_word prev_pc;
    logic                 have_prev;

    lc3b_pipeline lc3b_pipeline_inst (
        .clk(clk), .rst_n(rst_n), .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_we(dmem_we), .dmem_byte_sel(dmem_byte_sel)
    );

    always #20 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[7:1]];
    assign dmem_rdata = dmem[dmem_addr[8:1]];

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= seed_words[i];   // reload seed image
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[8:1]] <= dmem_wdata;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // generic LC-3b field layout {opcode, [11:9], [8:6], [5:0]}
    function automatic lc3b_types::lc3b_word enc(input logic [3:0] op, input lc3b_types::lc3b_reg a,
                                                 input lc3b_types::lc3b_reg b, input logic [5:0] low);
        return {op, a, b, low};
    endfunction

    function automatic logic [5:0] imm5(input int v);
        return {1'b1, v[4:0]};
    endfunction

    task automatic emit(input lc3b_types::lc3b_word w);
        prog.push_back(w);
    endtask

    task automatic gap();
        emit(lc3b_types::nop_instr);
        emit(lc3b_types::nop_instr);
    endtask

    task automatic expect_store(input string name, input lc3b_types::lc3b_word addr,
                                input lc3b_types::lc3b_word data);
        st_name.push_back(name);
        st_addr.push_back(addr);
        st_data.push_back(data);
    endtask

    // target is pc + 2 + (offset9 << 1)
    task automatic branch_to(input lc3b_types::lc3b_nzp nzp, input int off, input logic taken);
        lc3b_types::lc3b_word tgt;
        tgt = 16'(2 * prog.size() + 2 + 2 * off);
        if (taken)
            jump_target.push_back(tgt);
        emit({4'h0, nzp, off[8:0]});
    endtask

    task automatic check_word(input string name, input lc3b_types::lc3b_word exp,
                              input lc3b_types::lc3b_word act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end else begin
            $display("ok %s: %h", name, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end else begin
            $display("ok %s: %b", name, act);
        end
    endtask

    task automatic check_sel(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end else begin
            $display("ok %s: %b", name, act);
        end
    endtask

    task automatic build_program();
        emit(enc(4'h1, 3'd1, 3'd0, imm5(7)));           // add r1, r0, #7
        emit(enc(4'h1, 3'd2, 3'd0, imm5(-6)));          // add r2, r0, #-6
        gap();
        emit(enc(4'h1, 3'd3, 3'd1, 6'd2));              // add r3, r1, r2
        emit(enc(4'h5, 3'd4, 3'd2, imm5(13)));          // and r4, r2, #13
        emit(enc(4'h5, 3'd5, 3'd2, 6'd1));              // and r5, r2, r1
        emit(enc(4'h7, 3'd1, 3'd0, 6'd0));
        expect_store("add_imm_pos", 16'h0000, 16'h0007);
        emit(enc(4'h7, 3'd2, 3'd0, 6'd1));
        expect_store("add_imm_neg", 16'h0002, 16'hfffa);
        emit(enc(4'h7, 3'd3, 3'd0, 6'd2));
        expect_store("add_reg", 16'h0004, 16'h0001);     // 7 + -6
        emit(enc(4'h7, 3'd4, 3'd0, 6'd3));
        expect_store("and_imm", 16'h0006, 16'h0008);
        emit(enc(4'h7, 3'd5, 3'd0, 6'd4));
        expect_store("and_reg", 16'h0008, 16'h0002);
        emit(enc(4'h9, 3'd6, 3'd2, 6'h3f));             // not r6, r2
        emit(enc(4'h9, 3'd7, 3'd1, 6'h3f));             // not r7, r1
        emit(enc(4'hd, 3'd3, 3'd2, {2'b00, 4'd3}));     // lshf r3, r2, #3
        emit(enc(4'hd, 3'd4, 3'd2, {2'b01, 4'd2}));     // rshfl r4, r2, #2
        emit(enc(4'hd, 3'd5, 3'd2, {2'b11, 4'd2}));     // rshfa r5, r2, #2
        emit(enc(4'hd, 3'd1, 3'd6, {2'b11, 4'd1}));     // rshfa on a positive value
        emit(enc(4'hd, 3'd2, 3'd6, {2'b00, 4'd12}));
        emit(enc(4'h7, 3'd6, 3'd0, 6'd5));
        expect_store("not_neg", 16'h000a, 16'h0005);
        emit(enc(4'h7, 3'd7, 3'd0, 6'd6));
        expect_store("not_pos", 16'h000c, 16'hfff8);
        emit(enc(4'h7, 3'd3, 3'd0, 6'd7));
        expect_store("lshf_neg", 16'h000e, 16'hffd0);
        emit(enc(4'h7, 3'd4, 3'd0, 6'd8));
        expect_store("rshfl_neg", 16'h0010, 16'h3ffe);
        emit(enc(4'h7, 3'd5, 3'd0, 6'd9));
        expect_store("rshfa_neg", 16'h0012, 16'hfffe);
        emit(enc(4'h7, 3'd1, 3'd0, 6'd10));
        expect_store("rshfa_pos", 16'h0014, 16'h0002);
        emit(enc(4'h7, 3'd2, 3'd0, 6'd11));
        expect_store("lshf_pos", 16'h0016, 16'h5000);
        emit(enc(4'h1, 3'd7, 3'd0, imm5(1)));
        gap();
        emit(enc(4'hd, 3'd7, 3'd7, {2'b00, 4'd8}));     // r7 = 0x0100, load base
        gap();
        emit(enc(4'h6, 3'd1, 3'd7, 6'd0));              // ldr r1, r7, #0
        emit(enc(4'h6, 3'd2, 3'd7, 6'd5));
        emit(enc(4'h6, 3'd3, 3'd7, 6'h3d));             // offset -3
        emit(enc(4'h7, 3'd1, 3'd0, 6'd12));
        expect_store("ldr_word0", 16'h0018, seed_words[128]);
        emit(enc(4'h1, 3'd4, 3'd1, imm5(3)));
        emit(enc(4'h1, 3'd5, 3'd2, imm5(-1)));
        emit(enc(4'h1, 3'd6, 3'd3, 6'd3));              // add r6, r3, r3
        emit(enc(4'h7, 3'd2, 3'd0, 6'd13));
        expect_store("ldr_word5", 16'h001a, seed_words[133]);
        emit(enc(4'h7, 3'd3, 3'd0, 6'd14));
        expect_store("ldr_word_m3", 16'h001c, seed_words[125]);
        emit(enc(4'h7, 3'd4, 3'd0, 6'd15));
        expect_store("ldr_add_imm", 16'h001e, seed_words[128] + 16'd3);
        emit(enc(4'h7, 3'd5, 3'd0, 6'd16));
        expect_store("ldr_add_neg", 16'h0020, seed_words[133] - 16'd1);
        emit(enc(4'h7, 3'd6, 3'd0, 6'd17));
        expect_store("ldr_add_reg", 16'h0022, seed_words[125] + seed_words[125]);
        emit(enc(4'h1, 3'd1, 3'd0, imm5(-1)));          // cc n from alu
        branch_to(3'b100, 4, 1'b1);
        for (int i = 20; i < 24; i++)
            emit(enc(4'h7, 3'd1, 3'd0, 6'(i)));         // skipped
        emit(enc(4'h5, 3'd2, 3'd0, imm5(5)));           // cc z from alu
        branch_to(3'b101, 3, 1'b0);
        emit(enc(4'h7, 3'd1, 3'd0, 6'd18));
        expect_store("br_alu_fall", 16'h0024, 16'hffff);
        emit(enc(4'h6, 3'd3, 3'd0, 6'd0));              // cc p from ldr
        branch_to(3'b001, 4, 1'b1);
        for (int i = 24; i < 28; i++)
            emit(enc(4'h7, 3'd3, 3'd0, 6'(i)));
        emit(enc(4'h6, 3'd4, 3'd0, 6'd1));              // cc n from ldr
        branch_to(3'b011, 2, 1'b0);
        emit(enc(4'h7, 3'd3, 3'd0, 6'd19));
        expect_store("br_ldr_fall", 16'h0026, 16'h0007);
        emit(enc(4'hc, 3'd0, 3'd7, 6'd0));              // jmp r7, unsupported
        emit(enc(4'he, 3'd1, 3'd0, 6'd5));              // lea r1, unsupported
        gap();
        emit(enc(4'h7, 3'd1, 3'd0, 6'd28));
        expect_store("unknown_op", 16'h0038, 16'hffff);
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (dmem_we) begin
                if (store_ptr < st_addr.size()) begin
                    check_word({st_name[store_ptr], " addr"}, st_addr[store_ptr], dmem_addr);
                    check_word({st_name[store_ptr], " data"}, st_data[store_ptr], dmem_wdata);
                    check_sel({st_name[store_ptr], " byte_sel"}, 2'b11, dmem_byte_sel);
                    store_ptr++;
                end else begin
                    errors++;
                    $display("unexpected store of %h to address %h", dmem_wdata, dmem_addr);
                end
            end
            if (have_prev && imem_addr != prev_pc + 16'd2) begin
                if (jump_ptr < jump_target.size()) begin
                    check_word($sformatf("branch %0d target", jump_ptr), jump_target[jump_ptr],
                               imem_addr);
                    jump_ptr++;
                end else begin
                    errors++;
                    $display("unexpected jump of the fetch address to %h", imem_addr);
                end
            end
            prev_pc   = imem_addr;
            have_prev = 1'b1;
        end
    end

    initial begin
        logic [31:0]          state;
        int                   cycles;
        int                   limit;
        lc3b_types::lc3b_word end_addr;
        clk       = 1'b0;
        rst_n     = 1'b0;
        store_ptr = 0;
        jump_ptr  = 0;
        checks    = 0;
        errors    = 0;
        have_prev = 1'b0;
        prev_pc   = '0;
        cycles    = 0;
        state     = 32'h989b_0de2;
        for (int i = 0; i < 256; i++) begin
            state         = xorshift32(state);
            seed_words[i] = state[31:16] ^ 16'(i);
        end
        build_program();
        for (int i = 0; i < 128; i++)
            imem[i] = (i < prog.size()) ? prog[i] : lc3b_types::nop_instr;
        limit    = 4 * prog.size() + 20;
        end_addr = 16'(2 * prog.size() + 10);   // last instruction has left WB

        repeat (3) begin
            @(negedge clk);
            check_word("reset imem_addr", 16'h0000, imem_addr);
            check_bit("reset dmem_we", 1'b0, dmem_we);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("after reset imem_addr", 16'h0000, imem_addr);
        check_bit("after reset dmem_we", 1'b0, dmem_we);

        while (imem_addr < end_addr && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        @(posedge clk);
        if (cycles >= limit) begin
            errors++;
            $display("timeout after %0d cycles, the stores did not all appear", cycles);
        end
        if (store_ptr != st_addr.size()) begin
            errors++;
            $display("missing stores: only %0d of %0d appeared", store_ptr, st_addr.size());
        end
        if (jump_ptr != jump_target.size()) begin
            errors++;
            $display("missing branches: %0d of %0d redirected fetch", jump_ptr,
                     jump_target.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule : tb_lc3b_pipeline

//--- build.f
lc3b_types.sv
control_rom.sv
regfile.sv
general_alu.sv
stage_reg.sv
cc_branch_unit.sv
lc3b_pipeline.sv
tb_lc3b_pipeline.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing -Wall -Wno-fatal
TOP      := tb_lc3b_pipeline
FILELIST := build.f
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "NO ERRORS" $(LOG); then echo "simulation passed"; \
	else echo "simulation failed"; exit 1; fi

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
